// ==== verilog.f ====
mandel_pkg.sv
iter_if.sv
escape_iter.sv
frame_bank.sv
partition_sweep.sv
mandel_top.sv
tb_mandel_top.sv

// ==== Bender.yml ====
package:
  name: mandel_render

sources:
  - mandel_pkg.sv
  - iter_if.sv
  - escape_iter.sv
  - frame_bank.sv
  - partition_sweep.sv
  - mandel_top.sv
  - target: test
    files:
      - tb_mandel_top.sv

// ==== tb_mandel_top.sv ====
module tb_mandel_top;

	timeunit 1ns;
	timeprecision 1ps;

	typedef mandel_pkg::coord_t coord_t;
	typedef mandel_pkg::count_t count_t;
	typedef mandel_pkg::color_t color_t;
	typedef mandel_pkg::cycles_t cycles_t;

	localparam int MAX_ITER = 32;
	localparam int FRAME_W = 8;
	localparam int FRAME_H = 4;
	localparam int PARTITIONS = 2;
	localparam int PIXELS = FRAME_W * FRAME_H;
	// Worst case for one partition, every point runs to the limit
	localparam int RENDER_CYCLES = PIXELS / PARTITIONS * (MAX_ITER + 4) + 20;
	// Six renders, four full frame reads, reset, hold time and slack
	localparam int WATCHDOG_CYCLES = 16 + 6 * PIXELS * (MAX_ITER + 4) + 4 * PIXELS * 3 + 500;

	// 4.23 constants for the model and the stimulus
	localparam coord_t Q_HALF = coord_t'(1 << 22);
	localparam coord_t Q_NEG_ONE = coord_t'(-(1 << 23));
	localparam coord_t Q_TWO = coord_t'(2 << 23);
	localparam coord_t Q_NEG_TWO = coord_t'(-(2 << 23));
	localparam coord_t Q_FOUR = coord_t'(4 << 23);

	logic clk;
	logic reset;
	logic start;
	coord_t init_x;
	coord_t init_y;
	coord_t x_step;
	coord_t y_step;
	mandel_pkg::pix_x_t read_x;
	mandel_pkg::pix_y_t read_y;
	logic busy;
	logic done;
	cycles_t cycle_count;
	color_t pixel;

	logic [31:0] lfsr;
	int errors;
	int checks;
	int tests;

	mandel_top #(
		.MAX_ITER  (MAX_ITER),
		.FRAME_W   (FRAME_W),
		.FRAME_H   (FRAME_H),
		.PARTITIONS(PARTITIONS)
	) i_dut (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.init_x     (init_x),
		.init_y     (init_y),
		.x_step     (x_step),
		.y_step     (y_step),
		.read_x     (read_x),
		.read_y     (read_y),
		.busy       (busy),
		.done       (done),
		.cycle_count(cycle_count),
		.pixel      (pixel)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Full signed product, sign bit on top of bits 48..23
	function automatic coord_t q_mul(input coord_t a, input coord_t b);
		logic signed [53:0] wa;
		logic signed [53:0] wb;
		logic signed [53:0] p;
		wa = a;
		wb = b;
		p = wa * wb;
		return {p[53], p[48:23]};
	endfunction

	// Escape-time count, all sums wrap at 27 bits
	function automatic count_t escape_count(input coord_t cr, input coord_t ci);
		coord_t zr;
		coord_t zi;
		coord_t zr2;
		coord_t zi2;
		coord_t nr;
		coord_t ni;
		coord_t mag;
		count_t n;
		zr = '0;
		zi = '0;
		zr2 = '0;
		zi2 = '0;
		n = '0;
		for (int i = 0; i <= MAX_ITER; i++) begin
			mag = zr2 + zi2;
			if (n >= MAX_ITER)
				return n;
			// Outside the box or the radius
			if (zr >= Q_TWO || zi >= Q_TWO || zr <= Q_NEG_TWO || zi <= Q_NEG_TWO || mag >= Q_FOUR)
				return n;
			nr = zr2 - zi2 + cr;
			ni = (q_mul(zr, zi) <<< 1) + ci;
			zr = nr;
			zi = ni;
			zr2 = q_mul(nr, nr);
			zi2 = q_mul(ni, ni);
			n = n + 1'b1;
		end
		return n;
	endfunction

	// Colour bands, truncating divides of the limit
	function automatic color_t expected_color(input count_t n);
		if (n >= MAX_ITER)
			return 8'h00;
		else if (n >= MAX_ITER / 2)
			return 8'h64;
		else if (n >= MAX_ITER / 4)
			return 8'h64;
		else if (n >= MAX_ITER / 8)
			return 8'hA9;
		else if (n >= MAX_ITER / 16)
			return 8'h65;
		else if (n >= MAX_ITER / 32)
			return 8'h25;
		else if (n >= MAX_ITER / 64)
			return 8'h6A;
		return 8'h52;
	endfunction

	// Galois LFSR, one step per bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_color(input string name, input color_t exp, input color_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_cycles(input string name, input cycles_t exp, input cycles_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// Drivers
	//////////////////////////////////////////////////

	// Start pulse with a region, returns at the following falling edge
	task automatic launch_render(input coord_t ix, input coord_t iy, input coord_t xs,
		input coord_t ys);
		@(posedge clk);
		start <= 1'b1;
		init_x <= ix;
		init_y <= iy;
		x_step <= xs;
		y_step <= ys;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
	endtask

	// Clock cycles from the accepted start edge until done, bounded
	task automatic wait_render(input string name, output int elapsed);
		int n;
		n = 0;
		while (!done && n < RENDER_CYCLES) begin
			@(negedge clk);
			n++;
		end
		elapsed = n;
		if (!done) begin
			errors++;
			$display("%s: render did not finish within %0d cycles", name, RENDER_CYCLES);
		end
	endtask

	// One cycle read latency
	task automatic read_pixel(input int x, input int y, output color_t c);
		@(posedge clk);
		read_x <= mandel_pkg::pix_x_t'(x);
		read_y <= mandel_pkg::pix_y_t'(y);
		@(posedge clk);
		@(negedge clk);
		c = pixel;
	endtask

	// Whole frame against the model
	task automatic check_frame(input string name, input coord_t ix, input coord_t iy,
		input coord_t xs, input coord_t ys);
		coord_t cr;
		coord_t ci;
		color_t got;
		color_t want;
		for (int y = 0; y < FRAME_H; y++) begin
			for (int x = 0; x < FRAME_W; x++) begin
				cr = ix + coord_t'(x) * xs;
				ci = iy + coord_t'(y) * ys;
				want = expected_color(escape_count(cr, ci));
				read_pixel(x, y, got);
				check_color($sformatf("%s pixel (%0d,%0d)", name, x, y), want, got);
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d failed checks", name, errors - errors_before);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		int e;
		e = errors;
		@(negedge clk);
		check_bit("reset_state busy", 1'b0, busy);
		check_bit("reset_state done", 1'b0, done);
		check_cycles("reset_state cycle_count", '0, cycle_count);
		report_test("reset_state", e);
	endtask

	// Grid holds c = 0 at x 4, y 2
	task automatic test_fixed_region();
		int e;
		int bc;
		e = errors;
		launch_render(Q_NEG_TWO, Q_NEG_ONE, Q_HALF, Q_HALF);
		wait_render("fixed_region", bc);
		check_frame("fixed_region", Q_NEG_TWO, Q_NEG_ONE, Q_HALF, Q_HALF);
		report_test("fixed_region", e);
	endtask

	task automatic test_random_regions();
		int e;
		int bc;
		coord_t ix;
		coord_t iy;
		coord_t xs;
		coord_t ys;
		e = errors;
		for (int r = 0; r < 2; r++) begin
			// Left part of the plane, small positive steps
			ix = Q_NEG_TWO + coord_t'(take_bits(24));
			iy = coord_t'(-(3 << 22)) + coord_t'(take_bits(23));
			xs = coord_t'(take_bits(21)) + coord_t'(1 << 16);
			ys = coord_t'(take_bits(21)) + coord_t'(1 << 16);
			launch_render(ix, iy, xs, ys);
			wait_render($sformatf("random_region %0d", r), bc);
			check_frame($sformatf("random_region %0d", r), ix, iy, xs, ys);
		end
		report_test("random_regions", e);
	endtask

	task automatic test_cycle_counter();
		int e;
		int bc;
		cycles_t held;
		e = errors;
		launch_render(Q_NEG_TWO, Q_NEG_ONE, Q_HALF, Q_HALF);
		wait_render("cycle_counter", bc);
		held = cycle_count;
		check_bit("cycle_counter nonzero", 1'b1, held != 0);
		// Busy drops together with done
		check_bit("cycle_counter busy low", 1'b0, busy);
		repeat (20) @(negedge clk);
		check_cycles("cycle_counter hold", held, cycle_count);
		// Cleared by the accepted start
		launch_render(Q_NEG_TWO, Q_NEG_ONE, Q_HALF, Q_HALF);
		check_cycles("cycle_counter clear", '0, cycle_count);
		check_bit("cycle_counter done low", 1'b0, done);
		wait_render("cycle_counter", bc);
		// One count per clock from the start edge to the done edge
		check_cycles("cycle_counter elapsed cycles", cycles_t'(bc), cycle_count);
		check_bit("cycle_counter minimum", 1'b1, cycle_count >= PIXELS / PARTITIONS);
		report_test("cycle_counter", e);
	endtask

	task automatic test_start_while_busy();
		int e;
		int bc;
		e = errors;
		launch_render(Q_NEG_TWO, Q_NEG_ONE, Q_HALF, Q_HALF);
		repeat (3) @(negedge clk);
		check_bit("start_while_busy busy", 1'b1, busy);
		// Different region, must be dropped
		launch_render(Q_NEG_ONE, Q_NEG_TWO, Q_HALF >>> 1, Q_HALF >>> 2);
		wait_render("start_while_busy", bc);
		check_frame("start_while_busy", Q_NEG_TWO, Q_NEG_ONE, Q_HALF, Q_HALF);
		report_test("start_while_busy", e);
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		init_x = '0;
		init_y = '0;
		x_step = '0;
		y_step = '0;
		read_x = '0;
		read_y = '0;
		lfsr = 32'h2e3853b3;
		errors = 0;
		checks = 0;
		tests = 0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		test_reset_state();
		test_fixed_region();
		test_random_regions();
		test_cycle_counter();
		test_start_while_busy();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("Watchdog timeout: the tests did not finish after %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== mandel_top.sv ====
module mandel_top #(
	parameter int MAX_ITER   = 256,
	parameter int FRAME_W    = 640,
	parameter int FRAME_H    = 480,
	parameter int PARTITIONS = 2
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  mandel_pkg::coord_t   init_x,
	input  mandel_pkg::coord_t   init_y,
	input  mandel_pkg::coord_t   x_step,
	input  mandel_pkg::coord_t   y_step,
	input  mandel_pkg::pix_x_t   read_x,
	input  mandel_pkg::pix_y_t   read_y,
	output logic                 busy,
	output logic                 done,
	output mandel_pkg::cycles_t  cycle_count,
	output mandel_pkg::color_t   pixel
);

	localparam int COLS = FRAME_W / PARTITIONS;
	localparam int DEPTH = COLS * FRAME_H;
	localparam int ADDR_W = $clog2(DEPTH);
	// At least one select bit, even with a single partition
	localparam int PART_W = (PARTITIONS > 1) ? $clog2(PARTITIONS) : 1;

	mandel_pkg::launch_state_t state;
	logic accept;
	logic launch;
	logic [PARTITIONS-1:0] sweep_done;

	// Region held for the whole render
	mandel_pkg::coord_t init_x_q;
	mandel_pkg::coord_t init_y_q;
	mandel_pkg::coord_t x_step_q;
	mandel_pkg::coord_t y_step_q;

	logic [PART_W-1:0] rd_part;
	logic [PART_W-1:0] rd_part_q;
	logic [ADDR_W-1:0] rd_addr;
	mandel_pkg::color_t bank_data [PARTITIONS];

	//////////////////////////////////////////////////
	// Launch FSM
	//////////////////////////////////////////////////

	// Start only counts when idle, ignored mid-render
	assign accept = (state == mandel_pkg::IDLE) && start;
	assign launch = (state == mandel_pkg::LAUNCH);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mandel_pkg::IDLE;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			case (state)
				mandel_pkg::IDLE: begin
					if (start) begin
						state <= mandel_pkg::LAUNCH;
						busy <= 1'b1;
						done <= 1'b0;
					end
				end
				// One cycle of sweep start
				mandel_pkg::LAUNCH: state <= mandel_pkg::RUN;
				mandel_pkg::RUN: begin
					// Wait for the slowest partition
					if (&sweep_done) begin
						state <= mandel_pkg::IDLE;
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
				default: state <= mandel_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			init_x_q <= init_x;
			init_y_q <= init_y;
			x_step_q <= x_step;
			y_step_q <= y_step;
		end
	end

	// Render time, frozen once busy drops
	always_ff @(posedge clk) begin
		if (reset)
			cycle_count <= '0;
		else if (accept)
			cycle_count <= '0;
		else if (busy)
			cycle_count <= cycle_count + 1'b1;
	end

	//////////////////////////////////////////////////
	// Sweep engines
	//////////////////////////////////////////////////

	for (genvar p = 0; p < PARTITIONS; p++) begin : g_part
		partition_sweep #(
			.MAX_ITER  (MAX_ITER),
			.FRAME_W   (FRAME_W),
			.FRAME_H   (FRAME_H),
			.PARTITIONS(PARTITIONS),
			.PART_ID   (p)
		) i_sweep (
			.clk    (clk),
			.reset  (reset),
			.start  (launch),
			.init_x (init_x_q),
			.init_y (init_y_q),
			.x_step (x_step_q),
			.y_step (y_step_q),
			.rd_addr(rd_addr),
			.done   (sweep_done[p]),
			.rd_data(bank_data[p])
		);
	end

	//////////////////////////////////////////////////
	// Pixel read port
	//////////////////////////////////////////////////

	// Column x lives in bank x mod PARTITIONS
	assign rd_part = PART_W'(read_x % PARTITIONS);
	assign rd_addr = ADDR_W'(read_y * COLS + read_x / PARTITIONS);

	// Bank select lines up with the registered RAM read
	always_ff @(posedge clk) begin
		rd_part_q <= rd_part;
	end

	assign pixel = bank_data[rd_part_q];

endmodule

// ==== partition_sweep.sv ====
module partition_sweep #(
	parameter int MAX_ITER   = 256,
	parameter int FRAME_W    = 640,
	parameter int FRAME_H    = 480,
	parameter int PARTITIONS = 2,
	parameter int PART_ID    = 0
) (
	input  logic                                               clk,
	input  logic                                               reset,
	input  logic                                               start,
	input  mandel_pkg::coord_t                                 init_x,
	input  mandel_pkg::coord_t                                 init_y,
	input  mandel_pkg::coord_t                                 x_step,
	input  mandel_pkg::coord_t                                 y_step,
	input  logic [$clog2(FRAME_W / PARTITIONS * FRAME_H)-1:0]  rd_addr,
	output logic                                               done,
	output mandel_pkg::color_t                                 rd_data
);

	// Columns owned by this partition per row
	localparam int COLS = FRAME_W / PARTITIONS;
	localparam int DEPTH = COLS * FRAME_H;
	localparam int ADDR_W = $clog2(DEPTH);

	mandel_pkg::sweep_state_t state;
	mandel_pkg::coord_t first_cr;
	mandel_pkg::coord_t stride;
	mandel_pkg::coord_t cur_cr;
	mandel_pkg::coord_t cur_ci;
	mandel_pkg::pix_x_t col;
	mandel_pkg::pix_y_t row;
	logic [ADDR_W-1:0] wr_addr;
	logic we;

	iter_if it ();

	escape_iter #(
		.MAX_ITER(MAX_ITER)
	) i_engine (
		.clk  (clk),
		.reset(reset),
		.it   (it)
	);

	//////////////////////////////////////////////////
	// Pixel walk
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mandel_pkg::SW_IDLE;
			col <= '0;
			row <= '0;
			wr_addr <= '0;
		end else if (start) begin
			state <= mandel_pkg::SW_ISSUE;
			col <= '0;
			row <= '0;
			wr_addr <= '0;
		end else begin
			case (state)
				mandel_pkg::SW_ISSUE: state <= mandel_pkg::SW_WAIT;
				mandel_pkg::SW_WAIT: begin
					// Colour goes out this cycle, step to the next pixel
					if (it.done) begin
						wr_addr <= wr_addr + 1'b1;
						state <= mandel_pkg::SW_ISSUE;
						if (col == mandel_pkg::pix_x_t'(COLS - 1)) begin
							col <= '0;
							row <= row + 1'b1;
							if (row == mandel_pkg::pix_y_t'(FRAME_H - 1))
								state <= mandel_pkg::SW_DONE;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				default: state <= state;
			endcase
		end
	end

	// Point coordinates, interleaved columns
	always_ff @(posedge clk) begin
		if (start) begin
			first_cr <= init_x + mandel_pkg::coord_t'(PART_ID) * x_step;
			cur_cr <= init_x + mandel_pkg::coord_t'(PART_ID) * x_step;
			stride <= mandel_pkg::coord_t'(PARTITIONS) * x_step;
			cur_ci <= init_y;
		end else if (state == mandel_pkg::SW_WAIT && it.done) begin
			if (col == mandel_pkg::pix_x_t'(COLS - 1)) begin
				// Back to this partition's first column, one row down
				cur_cr <= first_cr;
				cur_ci <= cur_ci + y_step;
			end else begin
				cur_cr <= cur_cr + stride;
			end
		end
	end

	assign it.start = (state == mandel_pkg::SW_ISSUE);
	assign it.cr = cur_cr;
	assign it.ci = cur_ci;

	assign we = (state == mandel_pkg::SW_WAIT) && it.done;
	assign done = (state == mandel_pkg::SW_DONE);

	frame_bank #(
		.DEPTH (DEPTH),
		.ADDR_W(ADDR_W)
	) i_bank (
		.clk    (clk),
		.we     (we),
		.wr_addr(wr_addr),
		.rd_addr(rd_addr),
		.wr_data(mandel_pkg::palette(it.count, mandel_pkg::count_t'(MAX_ITER))),
		.rd_data(rd_data)
	);

endmodule

// ==== frame_bank.sv ====
module frame_bank #(
	parameter int DEPTH  = 1024,
	parameter int ADDR_W = 10
) (
	input  logic                clk,
	input  logic                we,
	input  logic [ADDR_W-1:0]   wr_addr,
	input  logic [ADDR_W-1:0]   rd_addr,
	input  mandel_pkg::color_t  wr_data,
	output mandel_pkg::color_t  rd_data
);

	// One colour byte per pixel of the partition
	mandel_pkg::color_t mem [DEPTH];

	// Write port from the sweep, registered read for the pixel port
	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== escape_iter.sv ====
module escape_iter #(
	parameter int MAX_ITER = 256
) (
	input  logic   clk,
	input  logic   reset,
	iter_if.engine it
);

	// Point under test, held for the whole run
	mandel_pkg::coord_t cr;
	mandel_pkg::coord_t ci;
	// z and its squares
	mandel_pkg::coord_t zr;
	mandel_pkg::coord_t zi;
	mandel_pkg::coord_t zr_sq;
	mandel_pkg::coord_t zi_sq;
	mandel_pkg::coord_t zr_next;
	mandel_pkg::coord_t zi_next;
	mandel_pkg::coord_t mag;
	mandel_pkg::count_t count;
	logic active;
	logic done;
	logic escaped;
	logic finish;

	//////////////////////////////////////////////////
	// One z step per cycle
	//////////////////////////////////////////////////

	assign zr_next = zr_sq - zi_sq + cr;
	// 2*zr*zi + ci
	assign zi_next = (mandel_pkg::fix_mul(zr, zi) <<< 1) + ci;
	// Wraps at 27 bits, same as the squares
	assign mag = zr_sq + zi_sq;

	// Box test first, then the radius test
	assign escaped = (zr >= mandel_pkg::TWO) || (zi >= mandel_pkg::TWO) ||
		(zr <= mandel_pkg::NEG_TWO) || (zi <= mandel_pkg::NEG_TWO) ||
		(mag >= mandel_pkg::FOUR);
	assign finish = (count >= mandel_pkg::count_t'(MAX_ITER)) || escaped;

	// Run control and count
	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else if (it.start) begin
			active <= 1'b1;
			done <= 1'b0;
			count <= '0;
		end else if (active) begin
			if (finish) begin
				// Count frozen from here until the next start
				active <= 1'b0;
				done <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (it.start) begin
			cr <= it.cr;
			ci <= it.ci;
			zr <= '0;
			zi <= '0;
			zr_sq <= '0;
			zi_sq <= '0;
		end else if (active && !finish) begin
			zr <= zr_next;
			zi <= zi_next;
			zr_sq <= mandel_pkg::fix_mul(zr_next, zr_next);
			zi_sq <= mandel_pkg::fix_mul(zi_next, zi_next);
		end
	end

	assign it.count = count;
	assign it.done = done;

endmodule

// ==== iter_if.sv ====
interface iter_if;

	// Point request from the sweep
	logic start;
	mandel_pkg::coord_t cr;
	mandel_pkg::coord_t ci;

	// Result back from the engine, count valid while done is high
	mandel_pkg::count_t count;
	logic done;

	modport sweep (
		output start, cr, ci,
		input  count, done
	);

	modport engine (
		input  start, cr, ci,
		output count, done
	);

endinterface

// ==== mandel_pkg.sv ====
package mandel_pkg;

	//////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////

	// Signed 4.23 fixed point
	typedef logic signed [26:0] coord_t;
	typedef logic [15:0] count_t;
	// RGB332, red on top, blue in the low two bits
	typedef logic [7:0] color_t;
	typedef logic [9:0] pix_x_t;
	typedef logic [9:0] pix_y_t;
	typedef logic [31:0] cycles_t;

	// Top-level launch sequence
	typedef enum logic [1:0] {IDLE, LAUNCH, RUN} launch_state_t;
	// Per-partition pixel walk
	typedef enum logic [1:0] {SW_IDLE, SW_ISSUE, SW_WAIT, SW_DONE} sweep_state_t;

	//////////////////////////////////////////////////
	// Fixed-point constants
	//////////////////////////////////////////////////

	localparam int FRAC_BITS = 23;
	localparam coord_t TWO = coord_t'(2 << FRAC_BITS);
	localparam coord_t NEG_TWO = coord_t'(-(2 << FRAC_BITS));
	localparam coord_t FOUR = coord_t'(4 << FRAC_BITS);

	// 4.23 multiply, keeps the sign and drops the top integer bits
	function automatic coord_t fix_mul(input coord_t a, input coord_t b);
		logic signed [53:0] prod;
		prod = a * b;
		return {prod[53], prod[2 * FRAC_BITS + 2:FRAC_BITS]};
	endfunction

	// Iteration count to colour, coarse bands toward the set
	function automatic color_t palette(input count_t count, input count_t max_iter);
		if (count >= max_iter)
			return 8'h00;
		else if (count >= (max_iter >> 1))
			return 8'h64;
		else if (count >= (max_iter >> 2))
			return 8'h64;
		else if (count >= (max_iter >> 3))
			return 8'hA9;
		else if (count >= (max_iter >> 4))
			return 8'h65;
		else if (count >= (max_iter >> 5))
			return 8'h25;
		else if (count >= (max_iter >> 6))
			return 8'h6A;
		else
			return 8'h52;
	endfunction

endpackage
